/* hdl/tile_pkg.sv */
package tile_pkg;

    // one bit per op, so only three codes are valid.
    typedef logic [2:0] op_t;

    localparam op_t OP_ADD = 3'd1;
    localparam op_t OP_SUB = 3'd2;
    localparam op_t OP_DOT = 3'd4;

    localparam int TILE_LEN          = 16;
    localparam int DOT_BYTES         = 4;
    localparam int ADDR_W            = 10;
    localparam int TILE_IDX_W        = 3;
    localparam int ELEM_W            = $clog2(TILE_LEN); // element index width.
    localparam int OPERAND_STRIDE    = 16;
    localparam int DOT_RESULT_STRIDE = 32;

    typedef logic [7:0] byte_t;

    // element 0 sits in the low byte.
    typedef byte_t [TILE_LEN-1:0] tile_t;

    // the accumulator is summed as a word and written out byte by byte.
    typedef union packed {
        logic [31:0]           sum;
        byte_t [DOT_BYTES-1:0] bytes;
    } dot_acc_u;

endpackage

/* hdl/tile_sequencer.sv */
`timescale 1ns/1ps

module tile_sequencer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  tile_pkg::op_t                   op_code,
    input  logic [tile_pkg::TILE_IDX_W-1:0] tile_i,
    input  logic [tile_pkg::TILE_IDX_W-1:0] tile_j,
    input  logic                            load_done,
    input  logic                            alu_done,
    input  logic                            write_done,
    output tile_pkg::op_t                   op,
    output logic [tile_pkg::TILE_IDX_W-1:0] cur_tile_i,
    output logic [tile_pkg::TILE_IDX_W-1:0] cur_tile_j,
    output logic                            load_start,
    output logic                            alu_start,
    output logic                            write_start,
    output logic                            done
);
    import tile_pkg::*;

    enum logic [1:0] {IDLE, LOAD, COMPUTE, WRITE} state;

    logic op_ok;

    assign op_ok = (op_code == OP_ADD) || (op_code == OP_SUB) || (op_code == OP_DOT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            op          <= '0;
            cur_tile_i  <= '0;
            cur_tile_j  <= '0;
            load_start  <= 1'b0;
            alu_start   <= 1'b0;
            write_start <= 1'b0;
            done        <= 1'b0;
        end else begin
            load_start  <= 1'b0;
            alu_start   <= 1'b0;
            write_start <= 1'b0;
            done        <= 1'b0;
            case (state)
                IDLE: begin
                    // unknown op codes are dropped here and never reach the datapath.
                    if (start && op_ok) begin
                        op         <= op_code;
                        cur_tile_i <= tile_i;
                        cur_tile_j <= tile_j;
                        load_start <= 1'b1;
                        state      <= LOAD;
                    end
                end
                LOAD: begin
                    if (load_done) begin
                        alu_start <= 1'b1;
                        state     <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    if (alu_done) begin
                        write_start <= 1'b1;
                        state       <= WRITE;
                    end
                end
                WRITE: begin
                    if (write_done) begin
                        done  <= 1'b1; // one cycle after the last byte is written.
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // the three phases never overlap.
    a_one_phase: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({load_start, alu_start, write_start}))
        else $error("more than one phase started in the same cycle");

endmodule

/* hdl/tile_loader.sv */
`timescale 1ns/1ps

module tile_loader (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            load_start,
    input  logic [tile_pkg::TILE_IDX_W-1:0] tile_i,
    input  logic [tile_pkg::TILE_IDX_W-1:0] tile_j,
    input  tile_pkg::byte_t                 sram_a_dout,
    input  tile_pkg::byte_t                 sram_b_dout,
    output logic                            sram_a_ce,
    output logic                            sram_b_ce,
    output logic [tile_pkg::ADDR_W-1:0]     sram_a_addr,
    output logic [tile_pkg::ADDR_W-1:0]     sram_b_addr,
    output tile_pkg::tile_t                 tile_a,
    output tile_pkg::tile_t                 tile_b,
    output logic                            load_done
);
    import tile_pkg::*;

    logic              rd_active;
    logic [ELEM_W-1:0] rd_idx;
    logic              cap_valid;
    logic [ELEM_W-1:0] cap_idx;

    // read side issues one address per cycle on both SRAMs.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_active <= 1'b0;
            rd_idx    <= '0;
        end else if (load_start) begin
            rd_active <= 1'b1;
            rd_idx    <= '0;
        end else if (rd_active) begin
            rd_active <= (rd_idx != ELEM_W'(TILE_LEN - 1));
            rd_idx    <= rd_idx + 1'b1;
        end
    end

    assign sram_a_ce   = rd_active;
    assign sram_b_ce   = rd_active;
    assign sram_a_addr = ADDR_W'(tile_i * OPERAND_STRIDE) + ADDR_W'(rd_idx);
    assign sram_b_addr = ADDR_W'(tile_j * OPERAND_STRIDE) + ADDR_W'(rd_idx);

    // the SRAMs answer one cycle after the address, so the index is delayed to match.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_valid <= 1'b0;
            cap_idx   <= '0;
            load_done <= 1'b0;
        end else begin
            cap_valid <= rd_active;
            cap_idx   <= rd_idx;
            load_done <= cap_valid && (cap_idx == ELEM_W'(TILE_LEN - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (cap_valid) begin
            tile_a[cap_idx] <= sram_a_dout;
            tile_b[cap_idx] <= sram_b_dout;
        end
    end

    // a read burst only begins right after the sequencer asks for one.
    a_ce_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sram_a_ce || sram_b_ce) |-> $past(load_start))
        else $error("operand read started without load_start");

endmodule

/* hdl/tile_alu.sv */
`timescale 1ns/1ps

module tile_alu (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            alu_start,
    input  tile_pkg::op_t   op,
    input  tile_pkg::tile_t tile_a,
    input  tile_pkg::tile_t tile_b,
    output tile_pkg::tile_t result,
    output logic            alu_done
);
    import tile_pkg::*;

    logic              dot_busy;
    logic [ELEM_W-1:0] dot_idx;
    logic              dot_last;
    logic [15:0]       prod;
    dot_acc_u          acc;
    dot_acc_u          acc_next;

    assign dot_last = dot_busy && (dot_idx == ELEM_W'(TILE_LEN - 1));
    assign prod     = tile_a[dot_idx] * tile_b[dot_idx]; // unsigned 8x8 product.

    always_comb begin
        acc_next.sum = acc.sum + 32'(prod);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dot_busy <= 1'b0;
            dot_idx  <= '0;
            alu_done <= 1'b0;
        end else begin
            alu_done <= 1'b0;
            if (alu_start) begin
                if (op == OP_DOT) begin
                    dot_busy <= 1'b1;
                    dot_idx  <= '0;
                end else begin
                    alu_done <= 1'b1; // element-wise ops finish in a single cycle.
                end
            end else if (dot_busy) begin
                dot_idx <= dot_idx + 1'b1;
                if (dot_last) begin
                    dot_busy <= 1'b0;
                    alu_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            acc.sum <= '0;
        end else if (dot_busy) begin
            acc <= acc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start && (op != OP_DOT)) begin
            for (int n = 0; n < TILE_LEN; n++) begin
                result[n] <= (op == OP_SUB) ? tile_a[n] - tile_b[n] : tile_a[n] + tile_b[n];
            end
        end else if (dot_last) begin
            // the sum goes out least significant byte first.
            for (int d = 0; d < DOT_BYTES; d++) begin
                result[d] <= acc_next.bytes[d];
            end
        end
    end

    // done trails its start by the latency of the op held by the sequencer.
    a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        alu_done |-> ((op == OP_DOT) ? $past(alu_start, TILE_LEN + 1) : $past(alu_start)))
        else $error("alu_done without a matching alu_start");

endmodule

/* hdl/result_writer.sv */
`timescale 1ns/1ps

module result_writer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            write_start,
    input  tile_pkg::op_t                   op,
    input  logic [tile_pkg::TILE_IDX_W-1:0] tile_i,
    input  tile_pkg::tile_t                 result,
    output logic                            sram_c_ce,
    output logic                            sram_c_we,
    output logic [tile_pkg::ADDR_W-1:0]     sram_c_addr,
    output tile_pkg::byte_t                 sram_c_din,
    output logic                            write_done
);
    import tile_pkg::*;

    logic              wr_active;
    logic [ELEM_W-1:0] wr_idx;
    logic [ELEM_W-1:0] wr_last;
    logic [ADDR_W-1:0] wr_base;

    // dot results are only four bytes but sit on a wider stride in C.
    assign wr_last = (op == OP_DOT) ? ELEM_W'(DOT_BYTES - 1) : ELEM_W'(TILE_LEN - 1);
    assign wr_base = (op == OP_DOT) ? ADDR_W'(tile_i * DOT_RESULT_STRIDE)
                                    : ADDR_W'(tile_i * OPERAND_STRIDE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_active  <= 1'b0;
            wr_idx     <= '0;
            write_done <= 1'b0;
        end else begin
            write_done <= wr_active && (wr_idx == wr_last);
            if (write_start) begin
                wr_active <= 1'b1;
                wr_idx    <= '0;
            end else if (wr_active) begin
                wr_idx <= wr_idx + 1'b1;
                if (wr_idx == wr_last) begin
                    wr_active <= 1'b0;
                end
            end
        end
    end

    assign sram_c_ce   = wr_active;
    assign sram_c_we   = wr_active; // C is only ever written.
    assign sram_c_addr = wr_base + ADDR_W'(wr_idx);
    assign sram_c_din  = result[wr_idx];

    // the byte count and the base address rely on op and tile_i holding for the whole burst.
    a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        sram_c_we |-> ($stable(op) && $stable(tile_i)))
        else $error("op or tile_i changed during an SRAM C write burst");

endmodule

/* hdl/tile_processor.sv */
`timescale 1ns/1ps

module tile_processor (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  tile_pkg::op_t                   op_code,
    input  logic [tile_pkg::TILE_IDX_W-1:0] tile_i,
    input  logic [tile_pkg::TILE_IDX_W-1:0] tile_j,
    input  tile_pkg::byte_t                 sram_a_dout,
    input  tile_pkg::byte_t                 sram_b_dout,
    output logic                            sram_a_ce,
    output logic [tile_pkg::ADDR_W-1:0]     sram_a_addr,
    output logic                            sram_b_ce,
    output logic [tile_pkg::ADDR_W-1:0]     sram_b_addr,
    output logic                            sram_c_ce,
    output logic                            sram_c_we,
    output logic [tile_pkg::ADDR_W-1:0]     sram_c_addr,
    output tile_pkg::byte_t                 sram_c_din,
    output logic                            done
);
    import tile_pkg::*;

    op_t                   op;
    logic [TILE_IDX_W-1:0] cur_tile_i;
    logic [TILE_IDX_W-1:0] cur_tile_j;
    logic                  load_start;
    logic                  load_done;
    logic                  alu_start;
    logic                  alu_done;
    logic                  write_start;
    logic                  write_done;
    tile_t                 tile_a;
    tile_t                 tile_b;
    tile_t                 result;

    tile_sequencer i_tile_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .op_code     (op_code),
        .tile_i      (tile_i),
        .tile_j      (tile_j),
        .load_done   (load_done),
        .alu_done    (alu_done),
        .write_done  (write_done),
        .op          (op),
        .cur_tile_i  (cur_tile_i),
        .cur_tile_j  (cur_tile_j),
        .load_start  (load_start),
        .alu_start   (alu_start),
        .write_start (write_start),
        .done        (done)
    );

    tile_loader i_tile_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_start  (load_start),
        .tile_i      (cur_tile_i),
        .tile_j      (cur_tile_j),
        .sram_a_dout (sram_a_dout),
        .sram_b_dout (sram_b_dout),
        .sram_a_ce   (sram_a_ce),
        .sram_b_ce   (sram_b_ce),
        .sram_a_addr (sram_a_addr),
        .sram_b_addr (sram_b_addr),
        .tile_a      (tile_a),
        .tile_b      (tile_b),
        .load_done   (load_done)
    );

    tile_alu i_tile_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .alu_start (alu_start),
        .op        (op),
        .tile_a    (tile_a),
        .tile_b    (tile_b),
        .result    (result),
        .alu_done  (alu_done)
    );

    // results always land at the A tile index.
    result_writer i_result_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .write_start (write_start),
        .op          (op),
        .tile_i      (cur_tile_i),
        .result      (result),
        .sram_c_ce   (sram_c_ce),
        .sram_c_we   (sram_c_we),
        .sram_c_addr (sram_c_addr),
        .sram_c_din  (sram_c_din),
        .write_done  (write_done)
    );

endmodule

/* test/sram_model.sv */
`timescale 1ns/1ps

module sram_model (
    input  logic                        clk,
    input  logic                        ce,
    input  logic                        we,
    input  logic [tile_pkg::ADDR_W-1:0] addr,
    input  tile_pkg::byte_t             din,
    output tile_pkg::byte_t             dout
);
    import tile_pkg::*;

    // the testbench loads and inspects this array directly.
    byte_t mem [2**ADDR_W];

    // reads and writes both act on the rising edge.
    always @(posedge clk) begin
        if (ce) begin
            if (we) begin
                mem[addr] <= din;
            end else begin
                dout <= mem[addr]; // read data shows up one cycle after the address.
            end
        end
    end

endmodule

/* test/tb_tile_processor.sv */
`timescale 1ns/1ps

module tb_tile_processor;
    import tile_pkg::*;

    typedef struct packed {
        op_t                   op;
        logic [TILE_IDX_W-1:0] ti;
        logic [TILE_IDX_W-1:0] tj;
        logic                  inject;
    } test_entry_t;

    localparam int NUM_TESTS  = 10;
    localparam int RUN_LIMIT  = 80;
    localparam int INJECT_AT  = 8;
    localparam int SETTLE     = 4;
    localparam int MAX_CYCLES = NUM_TESTS * 80 + 20;
    localparam int MEM_SIZE   = 2**ADDR_W;

    // op codes 0 and 3 are not part of the command set.
    test_entry_t tests [NUM_TESTS] = '{
        '{OP_ADD, 3'd0, 3'd1, 1'b0},
        '{OP_SUB, 3'd2, 3'd3, 1'b0},
        '{OP_DOT, 3'd1, 3'd4, 1'b0},
        '{OP_ADD, 3'd7, 3'd7, 1'b1},
        '{3'd0,   3'd5, 3'd2, 1'b0},
        '{OP_SUB, 3'd5, 3'd6, 1'b1},
        '{3'd3,   3'd1, 3'd1, 1'b0},
        '{OP_DOT, 3'd7, 3'd0, 1'b1},
        '{OP_SUB, 3'd4, 3'd4, 1'b0},
        '{OP_DOT, 3'd3, 3'd6, 1'b0}
    };

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    op_t                   op_code;
    logic [TILE_IDX_W-1:0] tile_i;
    logic [TILE_IDX_W-1:0] tile_j;
    byte_t                 sram_a_dout;
    byte_t                 sram_b_dout;
    logic                  sram_a_ce;
    logic [ADDR_W-1:0]     sram_a_addr;
    logic                  sram_b_ce;
    logic [ADDR_W-1:0]     sram_b_addr;
    logic                  sram_c_ce;
    logic                  sram_c_we;
    logic [ADDR_W-1:0]     sram_c_addr;
    byte_t                 sram_c_din;
    logic                  done;

    byte_t a_ref [MEM_SIZE];
    byte_t b_ref [MEM_SIZE];
    byte_t c_exp [MEM_SIZE];
    int    seed;
    int    error_count;
    int    check_count;
    int    done_count;
    int    c_write_count;
    int    cycle_count;

    tile_processor i_tile_processor (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .op_code     (op_code),
        .tile_i      (tile_i),
        .tile_j      (tile_j),
        .sram_a_dout (sram_a_dout),
        .sram_b_dout (sram_b_dout),
        .sram_a_ce   (sram_a_ce),
        .sram_a_addr (sram_a_addr),
        .sram_b_ce   (sram_b_ce),
        .sram_b_addr (sram_b_addr),
        .sram_c_ce   (sram_c_ce),
        .sram_c_we   (sram_c_we),
        .sram_c_addr (sram_c_addr),
        .sram_c_din  (sram_c_din),
        .done        (done)
    );

    sram_model sram_a (.clk(clk), .ce(sram_a_ce), .we(1'b0), .addr(sram_a_addr),
                       .din(8'h00), .dout(sram_a_dout));
    sram_model sram_b (.clk(clk), .ce(sram_b_ce), .we(1'b0), .addr(sram_b_addr),
                       .din(8'h00), .dout(sram_b_dout));
    sram_model sram_c (.clk(clk), .ce(sram_c_ce), .we(sram_c_we), .addr(sram_c_addr),
                       .din(sram_c_din), .dout());

    always #20 clk = ~clk;

    // flop outputs are sampled here before the edge updates them.
    always @(posedge clk) begin
        if (done) begin
            done_count++;
        end
        if (sram_c_ce && sram_c_we) begin
            c_write_count++;
        end
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("FAIL t=%0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    function automatic logic op_is_supported(input op_t op);
        return (op == OP_ADD) || (op == OP_SUB) || (op == OP_DOT);
    endfunction

    task automatic fill_memories();
        int rnd;
        for (int k = 0; k < MEM_SIZE; k++) begin
            rnd = $random(seed);
            a_ref[k] = rnd[7:0];
            rnd = $random(seed);
            b_ref[k] = rnd[15:8];
            sram_a.mem[k] = a_ref[k];
            sram_b.mem[k] = b_ref[k];
            c_exp[k] = 8'hA5; // sentinel for bytes that must never be written.
            sram_c.mem[k] = 8'hA5;
        end
    endtask

    task automatic check_idle_outputs();
        check_value("sram_a_ce", 32'(1'b0), 32'(sram_a_ce));
        check_value("sram_b_ce", 32'(1'b0), 32'(sram_b_ce));
        check_value("sram_c_ce", 32'(1'b0), 32'(sram_c_ce));
        check_value("sram_c_we", 32'(1'b0), 32'(sram_c_we));
        check_value("done", 32'(1'b0), 32'(done));
    endtask

    task automatic apply_reference(input test_entry_t entry);
        int          a_base;
        int          b_base;
        int          c_base;
        logic [31:0] dot_sum;
        a_base = int'(entry.ti) * OPERAND_STRIDE;
        b_base = int'(entry.tj) * OPERAND_STRIDE;
        dot_sum = '0;
        for (int n = 0; n < TILE_LEN; n++) begin
            if (entry.op == OP_ADD) begin
                c_exp[a_base + n] = a_ref[a_base + n] + b_ref[b_base + n];
            end else if (entry.op == OP_SUB) begin
                c_exp[a_base + n] = a_ref[a_base + n] - b_ref[b_base + n];
            end else begin
                dot_sum = dot_sum + 32'(a_ref[a_base + n]) * 32'(b_ref[b_base + n]);
            end
        end
        if (entry.op == OP_DOT) begin
            c_base = int'(entry.ti) * DOT_RESULT_STRIDE;
            for (int d = 0; d < DOT_BYTES; d++) begin
                c_exp[c_base + d] = dot_sum[8*d +: 8]; // least significant byte first.
            end
        end
    endtask

    task automatic run_entry(input int index, input test_entry_t entry);
        int dones_before;
        int writes_before;
        int waited;
        int exp_writes;
        dones_before = done_count;
        writes_before = c_write_count;
        if (!op_is_supported(entry.op)) begin
            exp_writes = 0;
        end else if (entry.op == OP_DOT) begin
            exp_writes = DOT_BYTES;
        end else begin
            exp_writes = TILE_LEN;
        end
        @(negedge clk);
        op_code = entry.op;
        tile_i = entry.ti;
        tile_j = entry.tj;
        start = 1'b1;
        waited = 0;
        while ((done_count == dones_before) && (waited < RUN_LIMIT)) begin
            @(negedge clk);
            waited++;
            start = entry.inject && (waited == INJECT_AT);
            if (start) begin
                op_code = OP_SUB; // a second command while busy must be ignored.
                tile_i = ~entry.ti;
                tile_j = ~entry.tj;
            end
        end
        start = 1'b0;
        repeat (SETTLE) @(negedge clk);
        check_value($sformatf("done pulses in test %0d", index),
                    32'(op_is_supported(entry.op)), 32'(done_count - dones_before));
        check_value($sformatf("sram_c writes in test %0d", index),
                    32'(exp_writes), 32'(c_write_count - writes_before));
        if (op_is_supported(entry.op)) begin
            apply_reference(entry);
        end
        for (int k = 0; k < MEM_SIZE; k++) begin
            check_value($sformatf("sram_c[%0d]", k), 32'(c_exp[k]), 32'(sram_c.mem[k]));
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        op_code = '0;
        tile_i = '0;
        tile_j = '0;
        seed = 30;
        error_count = 0;
        check_count = 0;
        done_count = 0;
        c_write_count = 0;
        cycle_count = 0;
        fill_memories();
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_idle_outputs();
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_entry(t, tests[t]);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/tile_pkg.sv
hdl/tile_sequencer.sv
hdl/tile_loader.sv
hdl/tile_alu.sv
hdl/result_writer.sv
hdl/tile_processor.sv
test/sram_model.sv
test/tb_tile_processor.sv

/* Makefile */
# Verilator build and run for the tile processor testbench.

VERILATOR ?= verilator
TOP       ?= tb_tile_processor
FLAGS     ?= --assert

.PHONY: sim clean

# the run passes only if the pass message shows up in the output.
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
